/* source/phy_mgmt_params.svh */
// PHY management constants
`ifndef PHY_MGMT_PARAMS_SVH
`define PHY_MGMT_PARAMS_SVH

// MDIO address of the copper SGMII PHY
`define PHY_MGMT_PHY_ADDR 5'd3

// power-on wait before the first frame, in clk_125mhz cycles
`define PHY_MGMT_INIT_DELAY 20'hFFFFF

// clk_125mhz cycles per MDC half period
// 125 / (2 * 3) gives about 20.8 MHz, under the 25 MHz PHY limit
`define PHY_MGMT_MDC_HALF 8'd3

// frame layout
`define PHY_MGMT_PREAMBLE_BITS 32
`define PHY_MGMT_FRAME_BITS 32

// clause 22 writes in the init sequence
`define PHY_MGMT_INIT_STEPS 12

// indirect access registers
`define PHY_MGMT_REG_REGCR 5'h0D
`define PHY_MGMT_REG_ADDAR 5'h0E

// REGCR codes for the address and data phases
`define PHY_MGMT_REGCR_ADDR 16'h001F
`define PHY_MGMT_REGCR_DATA 16'h401F

`endif

/* source/phy_mgmt_pkg.sv */
// PHY management types
package phy_mgmt_pkg;

    // one clause 22 write
    // start, op, PHY address and turnaround are fixed in the master
    typedef struct packed {
        logic [4:0]  reg_addr;
        logic [15:0] data;
    } mdio_cmd_t;

    // index into the init sequence, 0 to 11
    typedef logic [3:0] init_step_t;

    // extended registers reached through REGCR/ADDAR
    typedef enum logic [15:0] {
        // SGMII autonegotiation timer
        ext_reg_cfg4          = 16'h0031,
        // SGMII clock output control
        ext_reg_sgmiictl1     = 16'h00D3,
        // 10 Mb/s SGMII operation
        ext_reg_10m_sgmii_cfg = 16'h016F
    } ext_reg_t;

endpackage

/* source/phy_init_table.sv */
// PHY init command table
`timescale 1ns/1ps
`include "phy_mgmt_params.svh"

module phy_init_table
    import phy_mgmt_pkg::*;
(
    input  init_step_t step,
    output mdio_cmd_t  cmd
);

    // four MDIO writes per extended register
    localparam int num_ext = `PHY_MGMT_INIT_STEPS / 4;

    typedef struct packed {
        ext_reg_t    addr;
        logic [15:0] value;
    } ext_write_t;

    // extended register targets, written in list order
    localparam ext_write_t ext_writes [num_ext] = '{
        // autonegotiation timer to 11 ms
        '{ext_reg_cfg4,          16'h0070},
        // enable SGMII clock output
        '{ext_reg_sgmiictl1,     16'h4000},
        // enable 10 Mb/s operation
        '{ext_reg_10m_sgmii_cfg, 16'h0015}
    };

    logic [1:0] ext_idx;
    logic [1:0] phase;
    ext_write_t target;

    assign ext_idx = 2'(step >> 2);
    assign phase   = step[1:0];

    always_comb begin
        target = ext_writes[0];
        if (int'(ext_idx) < num_ext) begin
            target = ext_writes[ext_idx];
        end

        case (phase)
            2'd0: begin
                // REGCR, address phase
                cmd.reg_addr = `PHY_MGMT_REG_REGCR;
                cmd.data     = `PHY_MGMT_REGCR_ADDR;
            end
            2'd1: begin
                // ADDAR takes the extended register number
                cmd.reg_addr = `PHY_MGMT_REG_ADDAR;
                cmd.data     = target.addr;
            end
            2'd2: begin
                // REGCR, data phase
                cmd.reg_addr = `PHY_MGMT_REG_REGCR;
                cmd.data     = `PHY_MGMT_REGCR_DATA;
            end
            default: begin
                cmd.reg_addr = `PHY_MGMT_REG_ADDAR;
                cmd.data     = target.value;
            end
        endcase
    end

endmodule

/* source/phy_init_sequencer.sv */
// PHY init sequencer
`timescale 1ns/1ps
`include "phy_mgmt_params.svh"

module phy_init_sequencer
    import phy_mgmt_pkg::*;
#(
    parameter int unsigned init_delay = `PHY_MGMT_INIT_DELAY
) (
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,
    output init_step_t step,
    output logic       cmd_valid,
    input  logic       cmd_ready,
    output logic       init_done
);

    localparam logic [19:0] delay_load = 20'(init_delay);
    localparam init_step_t  last_step  = 4'(`PHY_MGMT_INIT_STEPS - 1);

    logic [19:0] delay_cnt;
    init_step_t  step_q;
    logic        valid_q;
    logic        done_q;
    logic        accept;

    assign accept = valid_q && cmd_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            delay_cnt <= delay_load;
            step_q    <= '0;
            valid_q   <= 1'b0;
            done_q    <= 1'b0;
        end else if (delay_cnt != 20'd0) begin
            // PHY still coming out of reset
            delay_cnt <= delay_cnt - 20'd1;
        end else if (accept) begin
            if (step_q == last_step) begin
                // whole table written, stay here until reset
                valid_q <= 1'b0;
                done_q  <= 1'b1;
            end else begin
                // next command offered right away
                // the master's busy period holds it
                step_q <= step_q + 4'd1;
            end
        end else if (!valid_q && !done_q) begin
            // countdown finished, offer step 0
            valid_q <= 1'b1;
        end
    end

    assign step      = step_q;
    assign cmd_valid = valid_q;
    assign init_done = done_q;

endmodule

/* source/mdio_master.sv */
// MDIO clause 22 write master
`timescale 1ns/1ps
`include "phy_mgmt_params.svh"

module mdio_master
    import phy_mgmt_pkg::*;
#(
    parameter logic [7:0] mdc_half = `PHY_MGMT_MDC_HALF
) (
    input  logic      clk_125mhz,
    input  logic      rst_125mhz,
    input  mdio_cmd_t cmd,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    output logic      mdc,
    output logic      mdio_o,
    output logic      mdio_oe
);

    localparam int frame_len = `PHY_MGMT_PREAMBLE_BITS + `PHY_MGMT_FRAME_BITS;
    localparam int bit_cnt_w = $clog2(frame_len);

    // start 01, write op 01, turnaround 10
    localparam logic [1:0] st_code = 2'b01;
    localparam logic [1:0] op_write = 2'b01;
    localparam logic [1:0] ta_code = 2'b10;

    logic [frame_len-1:0] shift_reg;
    logic [frame_len-1:0] frame;
    logic [7:0]           presc;
    logic [bit_cnt_w-1:0] bit_cnt;
    logic                 busy;
    logic                 mdc_q;
    logic                 accept;
    logic                 half_end;

    assign frame = {
        {`PHY_MGMT_PREAMBLE_BITS{1'b1}},
        st_code,
        op_write,
        `PHY_MGMT_PHY_ADDR,
        cmd.reg_addr,
        ta_code,
        cmd.data
    };

    assign accept   = cmd_valid && !busy;
    assign half_end = (presc == 8'd0);

    // control state
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            busy    <= 1'b0;
            mdc_q   <= 1'b0;
            presc   <= '0;
            bit_cnt <= '0;
        end else if (accept) begin
            // frame begins next cycle with MDC low
            busy    <= 1'b1;
            mdc_q   <= 1'b0;
            presc   <= mdc_half - 8'd1;
            bit_cnt <= bit_cnt_w'(frame_len - 1);
        end else if (busy) begin
            if (!half_end) begin
                presc <= presc - 8'd1;
            end else begin
                presc <= mdc_half - 8'd1;
                if (!mdc_q) begin
                    // rising edge, PHY samples the current bit
                    mdc_q <= 1'b1;
                end else begin
                    mdc_q <= 1'b0;
                    if (bit_cnt == '0) begin
                        // last falling edge closes the frame
                        busy <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
            end
        end
    end

    // frame data, shifted out MSB first
    always_ff @(posedge clk_125mhz) begin
        if (accept) begin
            shift_reg <= frame;
        end else if (busy && half_end && mdc_q) begin
            // advance on the falling edge so data is settled at the next rise
            shift_reg <= {shift_reg[frame_len-2:0], 1'b0};
        end
    end

    assign cmd_ready = !busy;
    assign mdc       = mdc_q;
    assign mdio_o    = busy && shift_reg[frame_len-1];
    assign mdio_oe   = busy;

endmodule

/* source/phy_mgmt_top.sv */
// PHY management top level
`timescale 1ns/1ps
`include "phy_mgmt_params.svh"

module phy_mgmt_top
    import phy_mgmt_pkg::*;
#(
    parameter int unsigned init_delay = `PHY_MGMT_INIT_DELAY
) (
    input  logic clk_125mhz,
    input  logic rst_125mhz,
    output logic phy_reset_n,
    output logic phy_mdc,
    output logic phy_mdio_o,
    output logic phy_mdio_t,
    output logic init_done
);

    init_step_t step;
    mdio_cmd_t  cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       mdio_oe;

    // PHY held in reset along with the core
    assign phy_reset_n = !rst_125mhz;

    phy_init_sequencer #(
        .init_delay(init_delay)
    ) i_sequencer (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .step(step),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .init_done(init_done)
    );

    phy_init_table i_table (
        .step(step),
        .cmd(cmd)
    );

    mdio_master #(
        .mdc_half(`PHY_MGMT_MDC_HALF)
    ) i_master (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .mdc(phy_mdc),
        .mdio_o(phy_mdio_o),
        .mdio_oe(mdio_oe)
    );

    // tristate control, pin released when high
    assign phy_mdio_t = !mdio_oe;

endmodule

/* tb/phy_mgmt_checker.sv */
// MDIO frame checker
`timescale 1ns/1ps
`include "phy_mgmt_params.svh"

module phy_mgmt_checker
    import phy_mgmt_pkg::*;
#(
    parameter int init_delay = 100
) (
    input  logic            clk_125mhz,
    input  logic            rst_125mhz,
    input  logic            phy_reset_n,
    input  logic            phy_mdc,
    input  logic            phy_mdio_o,
    input  logic            phy_mdio_t,
    input  logic            init_done,
    input  logic            test_active,
    input  logic [8*24-1:0] test_name,
    input  int              expect_frames,
    output int              tests_passed,
    output int              tests_failed
);

    localparam int steps     = `PHY_MGMT_INIT_STEPS;
    localparam int frame_len = `PHY_MGMT_PREAMBLE_BITS + `PHY_MGMT_FRAME_BITS;
    localparam int mdc_half  = `PHY_MGMT_MDC_HALF;

    // extended registers and their values, in write order
    logic [15:0] ext_addr [steps/4] = '{16'h0031, 16'h00D3, 16'h016F};
    logic [15:0] ext_value [steps/4] = '{16'h0070, 16'h4000, 16'h0015};

    mdio_cmd_t            exp_cmd [steps];
    logic [frame_len-1:0] bits;
    int                   bit_cnt;
    int                   phase_cnt;
    int                   frame_idx;
    int                   since_reset;
    int                   errors;
    logic                 mdc_q;
    logic                 oe_q;
    logic                 mdio_q;
    logic                 done_q;
    logic                 rst_q;
    logic                 active_q;
    logic                 oe;

    assign oe = !phy_mdio_t;

    initial begin : build_expected
        tests_passed = 0;
        tests_failed = 0;
        errors       = 0;
        frame_idx    = 0;
        since_reset  = 0;
        bits         = '0;
        {mdc_q, oe_q, mdio_q, done_q, rst_q, active_q} = '0;
        // REGCR address code, ADDAR register, REGCR data code, ADDAR value
        for (int k = 0; k < steps / 4; k++) begin
            exp_cmd[4*k]   = {`PHY_MGMT_REG_REGCR, `PHY_MGMT_REGCR_ADDR};
            exp_cmd[4*k+1] = {`PHY_MGMT_REG_ADDAR, ext_addr[k]};
            exp_cmd[4*k+2] = {`PHY_MGMT_REG_REGCR, `PHY_MGMT_REGCR_DATA};
            exp_cmd[4*k+3] = {`PHY_MGMT_REG_ADDAR, ext_value[k]};
        end
    end

    task automatic mismatch(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("FAILED %0s %0s: expected 0x%0h, actual 0x%0h",
                 test_name, what, expected, actual);
        errors++;
    endtask

    task automatic problem(input string text);
        $display("test %0s: %0s", test_name, text);
        errors++;
    endtask

    task automatic check_frame();
        string tag;
        tag = $sformatf("frame %0d", frame_idx + 1);
        if (bit_cnt != frame_len) begin
            mismatch({tag, " MDC periods"}, frame_len, bit_cnt);
        end
        if (bits[63:32] != 32'hFFFFFFFF) begin
            mismatch({tag, " preamble"}, 32'hFFFFFFFF, bits[63:32]);
        end
        // start 01 then write op 01
        if (bits[31:28] != 4'b0101) begin
            mismatch({tag, " start and op"}, 4'b0101, bits[31:28]);
        end
        if (bits[27:23] != `PHY_MGMT_PHY_ADDR) begin
            mismatch({tag, " PHY address"}, `PHY_MGMT_PHY_ADDR, bits[27:23]);
        end
        if (bits[17:16] != 2'b10) begin
            mismatch({tag, " turnaround"}, 2'b10, bits[17:16]);
        end
        if (frame_idx < steps) begin
            if (bits[22:18] != exp_cmd[frame_idx].reg_addr) begin
                mismatch({tag, " register"}, exp_cmd[frame_idx].reg_addr, bits[22:18]);
            end
            if (bits[15:0] != exp_cmd[frame_idx].data) begin
                mismatch({tag, " data"}, exp_cmd[frame_idx].data, bits[15:0]);
            end
        end
        frame_idx++;
    endtask

    task automatic check_pins();
        if (!oe && (phy_mdc || phy_mdio_o)) begin
            problem("MDC or MDIO driven while the master is idle");
        end
        if (oe && !oe_q) begin
            if (since_reset < init_delay) begin
                problem($sformatf("frame began %0d cycles after reset", since_reset));
            end
            if (frame_idx >= steps) begin
                problem("a frame started after the sequence was complete");
            end
            bit_cnt   = 0;
            phase_cnt = 1;
        end else if (oe_q) begin
            // the closing falling edge lands on the sample where the pin is released
            if (phy_mdc != mdc_q) begin
                if (phase_cnt != mdc_half) begin
                    mismatch($sformatf("frame %0d MDC phase length", frame_idx + 1),
                             mdc_half, phase_cnt);
                end
                phase_cnt = 1;
            end else begin
                phase_cnt++;
            end
        end
        if (oe && oe_q && phy_mdc && (phy_mdio_o != mdio_q)) begin
            problem("MDIO changed while MDC was high");
        end
        if (oe && phy_mdc && !mdc_q) begin
            bits = {bits[frame_len-2:0], phy_mdio_o};
            bit_cnt++;
        end
        if (!oe && oe_q) begin
            check_frame();
        end
        // done goes up as the last command is taken by the master
        if (init_done && !done_q && ((frame_idx != steps - 1) || !oe)) begin
            problem($sformatf("init_done rose after %0d frames", frame_idx));
        end
        if (!init_done && done_q) begin
            problem("init_done fell without a reset");
        end
    endtask

    task automatic finish_test();
        if (frame_idx != expect_frames) begin
            mismatch("frames after the last reset", expect_frames, frame_idx);
        end
        if (!init_done) begin
            problem("init_done low at the end of the test");
        end
        if (errors == 0) begin
            tests_passed++;
            $display("test %0s: passed, %0d frames checked", test_name, frame_idx);
        end else begin
            tests_failed++;
            $display("test %0s: failed with %0d errors", test_name, errors);
        end
        errors = 0;
    endtask

    always @(negedge clk_125mhz) begin
        if (phy_reset_n == rst_125mhz) begin
            problem("phy_reset_n is not the inverse of reset");
        end
        if (rst_125mhz) begin
            // pins settle one clock edge into reset
            if (rst_q && (phy_mdc || phy_mdio_o || !phy_mdio_t || init_done)) begin
                problem("MDIO pins or init_done active during reset");
            end
            frame_idx   = 0;
            since_reset = 0;
        end else begin
            since_reset++;
            check_pins();
        end
        if (!test_active && active_q) begin
            finish_test();
        end
        mdc_q    = phy_mdc;
        oe_q     = oe;
        mdio_q   = phy_mdio_o;
        done_q   = init_done;
        rst_q    = rst_125mhz;
        active_q = test_active;
    end

endmodule

/* tb/tb_phy_mgmt.sv */
// PHY management testbench
`timescale 1ns/1ps
`include "phy_mgmt_params.svh"

module tb_phy_mgmt;

    localparam int init_delay   = 100;
    localparam int reset_cycles = 16;
    localparam int steps        = `PHY_MGMT_INIT_STEPS;
    localparam int frame_cycles = 2 * `PHY_MGMT_MDC_HALF
                                  * (`PHY_MGMT_PREAMBLE_BITS + `PHY_MGMT_FRAME_BITS);
    localparam int n_tests      = 4;

    // one row per test with name, reset pulse cycle after release and frames expected
    // a pulse cycle of -1 means no second reset
    logic [8*24-1:0] name_tbl [n_tests] = '{
        "full_sequence",
        "reset_in_delay",
        "reset_mid_frame",
        "reset_in_last_frame"
    };
    int pulse_tbl [n_tests] = '{
        -1,
        init_delay / 2,
        init_delay + 5 * frame_cycles + 100,
        init_delay + 11 * frame_cycles + 60
    };
    int frames_tbl [n_tests] = '{steps, steps, steps, steps};

    logic            clk_125mhz;
    logic            rst_125mhz;
    logic            phy_reset_n;
    logic            phy_mdc;
    logic            phy_mdio_o;
    logic            phy_mdio_t;
    logic            init_done;
    logic            test_active;
    logic [8*24-1:0] test_name;
    int              expect_frames;
    int              tests_passed;
    int              tests_failed;
    logic            timed_out;

    phy_mgmt_top #(
        .init_delay(init_delay)
    ) i_phy_mgmt_top (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .phy_reset_n(phy_reset_n),
        .phy_mdc(phy_mdc),
        .phy_mdio_o(phy_mdio_o),
        .phy_mdio_t(phy_mdio_t),
        .init_done(init_done)
    );

    phy_mgmt_checker #(
        .init_delay(init_delay)
    ) i_checker (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .phy_reset_n(phy_reset_n),
        .phy_mdc(phy_mdc),
        .phy_mdio_o(phy_mdio_o),
        .phy_mdio_t(phy_mdio_t),
        .init_done(init_done),
        .test_active(test_active),
        .test_name(test_name),
        .expect_frames(expect_frames),
        .tests_passed(tests_passed),
        .tests_failed(tests_failed)
    );

    initial begin : clock_gen
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    // called 1 ns after a rising edge
    task automatic apply_reset();
        rst_125mhz = 1'b1;
        repeat (reset_cycles) @(posedge clk_125mhz);
        #1;
        rst_125mhz = 1'b0;
    endtask

    task automatic wait_for_done(input int limit, output logic seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < limit) begin
            @(negedge clk_125mhz);
            seen = init_done;
            waited++;
        end
    endtask

    function automatic int run_budget();
        int total;
        total = 0;
        for (int i = 0; i < n_tests; i++) begin
            total += init_delay + steps * frame_cycles + 200;
            // opening reset, tail after done and gap between tests
            total += 2 * reset_cycles + frame_cycles + 210;
            if (pulse_tbl[i] >= 0) begin
                total += pulse_tbl[i] + reset_cycles;
            end
        end
        return total;
    endfunction

    initial begin : watchdog
        int budget;
        budget = run_budget();
        repeat (budget) @(posedge clk_125mhz);
        $display("watchdog: no result after %0d cycles, run stopped", budget);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main
        logic seen;
        rst_125mhz    = 1'b1;
        test_active   = 1'b0;
        test_name     = '0;
        expect_frames = 0;
        timed_out     = 1'b0;
        for (int i = 0; i < n_tests && !timed_out; i++) begin
            @(posedge clk_125mhz);
            #1;
            test_name     = name_tbl[i];
            expect_frames = frames_tbl[i];
            test_active   = 1'b1;
            apply_reset();
            if (pulse_tbl[i] >= 0) begin
                repeat (pulse_tbl[i]) @(posedge clk_125mhz);
                #1;
                apply_reset();
            end
            wait_for_done(init_delay + steps * (frame_cycles + 2) + 200, seen);
            if (!seen) begin
                $display("test %0s: init_done did not rise in time", name_tbl[i]);
                timed_out = 1'b1;
            end else begin
                // let the last frame finish and watch for stray MDC edges
                repeat (frame_cycles + 200) @(posedge clk_125mhz);
            end
            @(posedge clk_125mhz);
            #1;
            test_active = 1'b0;
            repeat (3) @(posedge clk_125mhz);
        end
        $display("tests run: %0d, passed: %0d, failed: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (!timed_out && tests_failed == 0 && tests_passed == n_tests) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/phy_mgmt_pkg.sv
source/phy_init_table.sv
source/phy_init_sequencer.sv
source/mdio_master.sv
source/phy_mgmt_top.sv
tb/phy_mgmt_checker.sv
tb/tb_phy_mgmt.sv

/* Bender.yml */
package:
  name: phy_mgmt

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/phy_mgmt_pkg.sv
      - source/phy_init_table.sv
      - source/phy_init_sequencer.sv
      - source/mdio_master.sv
      - source/phy_mgmt_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/phy_mgmt_checker.sv
      - tb/tb_phy_mgmt.sv
